// File: hw/core_isa_pkg.sv
`default_nettype none

package core_isa_pkg;

    localparam int reg_addr_w = 5;

    // major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // funct3 values of the supported subset
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    typedef enum logic [2:0] {
        alu_reg,
        alu_imm,
        load,
        store,
        branch,
        jal,
        illegal
    } op_kind_t;

    typedef enum logic [2:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op
    } alu_op_t;

endpackage

`default_nettype wire

// File: hw/core_bus_pkg.sv
`default_nettype none

package core_bus_pkg;

    // data word and byte address widths
    localparam int word_w = 32;
    localparam int addr_w = 32;

    // arbiter grant encoding
    localparam logic rq_fetch = 1'b0;
    localparam logic rq_data  = 1'b1;

endpackage

`default_nettype wire

// File: hw/mem_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

// four-phase req/ack memory bus
interface mem_bus_if;
    import core_bus_pkg::*;

    logic              req;
    logic [addr_w-1:0] addr;
    logic              we;
    logic [word_w-1:0] wdata;
    logic              ack;
    logic [word_w-1:0] rdata;

    modport requester (output req, output addr, output we, output wdata,
                       input ack, input rdata);

    modport responder (input req, input addr, input we, input wdata,
                       output ack, output rdata);

endinterface

`default_nettype wire

// File: hw/core_decode.sv
`timescale 1ns/100ps
`default_nettype none

module core_decode (
    input  logic [core_bus_pkg::word_w-1:0]     inst,
    output core_isa_pkg::op_kind_t              kind,
    output core_isa_pkg::alu_op_t               alu_op,
    output logic [core_isa_pkg::reg_addr_w-1:0] rs1,
    output logic [core_isa_pkg::reg_addr_w-1:0] rs2,
    output logic [core_isa_pkg::reg_addr_w-1:0] rd,
    output logic [core_bus_pkg::word_w-1:0]     imm
);
    import core_isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    always_comb begin
        kind   = illegal;
        alu_op = add;
        imm    = '0;
        case (opcode)
            op_reg: begin
                if (funct7 == f7_base) begin
                    kind = alu_reg;
                    case (funct3)
                        f3_add_sub: alu_op = add;
                        f3_xor:     alu_op = xor_op;
                        f3_or:      alu_op = or_op;
                        f3_and:     alu_op = and_op;
                        default:    kind = illegal;
                    endcase
                end else if (funct7 == f7_sub && funct3 == f3_add_sub) begin
                    kind   = alu_reg;
                    alu_op = sub;
                end
            end
            op_imm: begin
                if (funct3 == f3_add_sub) kind = alu_imm;
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            op_load: begin
                if (funct3 == f3_word) kind = load;
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            op_store: begin
                if (funct3 == f3_word) kind = store;
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            op_branch: begin
                if (funct3 == f3_beq || funct3 == f3_bne) kind = branch;
                // b-type immediate with an implied bit 0
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            op_jal: begin
                kind = jal;
                imm  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: kind = illegal;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/core_alu.sv
`timescale 1ns/100ps
`default_nettype none

module core_alu (
    input  core_isa_pkg::alu_op_t           alu_op,
    input  logic [core_bus_pkg::word_w-1:0] a,
    input  logic [core_bus_pkg::word_w-1:0] b,
    output logic [core_bus_pkg::word_w-1:0] result,
    output logic                            equal
);
    import core_isa_pkg::*;

    // add also forms load/store addresses
    always_comb begin
        case (alu_op)
            add:     result = a + b;
            sub:     result = a - b;
            and_op:  result = a & b;
            or_op:   result = a | b;
            xor_op:  result = a ^ b;
            default: result = '0;
        endcase
    end

    // branch compare
    assign equal = (a == b);

endmodule

`default_nettype wire

// File: hw/core_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module core_regfile (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                we,
    input  logic [core_isa_pkg::reg_addr_w-1:0] waddr,
    input  logic [core_bus_pkg::word_w-1:0]     wdata,
    input  logic [core_isa_pkg::reg_addr_w-1:0] raddr1,
    input  logic [core_isa_pkg::reg_addr_w-1:0] raddr2,
    output logic [core_bus_pkg::word_w-1:0]     rdata1,
    output logic [core_bus_pkg::word_w-1:0]     rdata2
);
    import core_isa_pkg::*;
    import core_bus_pkg::*;

    // x0 has no storage
    logic [word_w-1:0] regs [1:2**reg_addr_w-1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 1; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hw/core_control.sv
`timescale 1ns/100ps
`default_nettype none

module core_control (
    input  logic                                clk,
    input  logic                                rstn,
    mem_bus_if.requester                        if_bus,
    mem_bus_if.requester                        d_bus,
    output logic                                halted,
    output logic [core_bus_pkg::word_w-1:0]     inst,
    input  core_isa_pkg::op_kind_t              kind,
    input  logic [core_isa_pkg::reg_addr_w-1:0] rd,
    input  logic [core_bus_pkg::word_w-1:0]     imm,
    output logic [core_bus_pkg::word_w-1:0]     alu_a,
    output logic [core_bus_pkg::word_w-1:0]     alu_b,
    input  logic [core_bus_pkg::word_w-1:0]     alu_result,
    input  logic                                equal,
    output logic                                rf_we,
    output logic [core_isa_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [core_bus_pkg::word_w-1:0]     rf_wdata,
    input  logic [core_bus_pkg::word_w-1:0]     rdata1,
    input  logic [core_bus_pkg::word_w-1:0]     rdata2
);
    import core_isa_pkg::*;
    import core_bus_pkg::*;

    typedef enum logic [6:0] {
        s_fetch      = 7'b0000001,
        s_fetch_wait = 7'b0000010,
        s_decode     = 7'b0000100,
        s_execute    = 7'b0001000,
        s_mem_wait   = 7'b0010000,
        s_write      = 7'b0100000,
        s_halt       = 7'b1000000
    } state_t;

    state_t                state;
    logic [addr_w-1:0]     pc;
    logic [addr_w-1:0]     next_pc;
    logic [word_w-1:0]     ir;
    logic [word_w-1:0]     imm_q;
    logic [word_w-1:0]     a_q;
    logic [word_w-1:0]     b_q;
    logic [word_w-1:0]     wb_data;
    op_kind_t              kind_q;
    logic [reg_addr_w-1:0] rd_q;
    logic                  wb_en;
    logic                  ack_seen;
    logic                  if_req;
    logic                  d_req;
    logic                  d_we;
    logic [addr_w-1:0]     d_addr;
    logic [word_w-1:0]     d_wdata;
    logic                  taken;

    assign inst  = ir;
    assign alu_a = a_q;
    // register operand only for R-type and branch compare
    assign alu_b = (kind_q == alu_reg || kind_q == branch) ? b_q : imm_q;
    assign taken = (ir[14:12] == f3_bne) ? !equal : equal;

    assign if_bus.req   = if_req;
    assign if_bus.addr  = pc;
    assign if_bus.we    = 1'b0;
    assign if_bus.wdata = '0;
    assign d_bus.req    = d_req;
    assign d_bus.addr   = d_addr;
    assign d_bus.we     = d_we;
    assign d_bus.wdata  = d_wdata;

    assign rf_we    = (state == s_write) && wb_en;
    assign rf_waddr = rd_q;
    assign rf_wdata = wb_data;
    assign halted   = (state == s_halt);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= s_fetch;
            pc       <= '0;
            if_req   <= 1'b0;
            d_req    <= 1'b0;
            d_we     <= 1'b0;
            ack_seen <= 1'b0;
            wb_en    <= 1'b0;
        end else begin
            case (state)
                s_fetch: begin
                    if_req <= 1'b1;
                    state  <= s_fetch_wait;
                end
                s_fetch_wait: begin
                    // drop req on ack, then wait for ack to fall
                    if (!ack_seen) begin
                        if (if_bus.ack) begin
                            if_req   <= 1'b0;
                            ack_seen <= 1'b1;
                        end
                    end else if (!if_bus.ack) begin
                        ack_seen <= 1'b0;
                        state    <= s_decode;
                    end
                end
                s_decode: state <= s_execute;
                s_execute: begin
                    case (kind_q)
                        alu_reg, alu_imm, jal: begin
                            wb_en <= 1'b1;
                            state <= s_write;
                        end
                        branch: begin
                            wb_en <= 1'b0;
                            state <= s_write;
                        end
                        load, store: begin
                            d_req <= 1'b1;
                            d_we  <= (kind_q == store);
                            wb_en <= (kind_q == load);
                            state <= s_mem_wait;
                        end
                        default: state <= s_halt;
                    endcase
                end
                s_mem_wait: begin
                    if (!ack_seen) begin
                        if (d_bus.ack) begin
                            d_req    <= 1'b0;
                            ack_seen <= 1'b1;
                        end
                    end else if (!d_bus.ack) begin
                        ack_seen <= 1'b0;
                        d_we     <= 1'b0;
                        state    <= s_write;
                    end
                end
                s_write: begin
                    pc    <= next_pc;
                    state <= s_fetch;
                end
                s_halt: state <= s_halt;
                default: state <= s_halt;
            endcase
        end
    end

    // instruction and operand capture
    always_ff @(posedge clk) begin
        case (state)
            s_fetch_wait: begin
                if (!ack_seen && if_bus.ack) ir <= if_bus.rdata;
            end
            s_decode: begin
                kind_q <= kind;
                rd_q   <= rd;
                imm_q  <= imm;
                a_q    <= rdata1;
                b_q    <= rdata2;
            end
            s_execute: begin
                wb_data <= (kind_q == jal) ? pc + addr_w'(4) : alu_result;
                if (kind_q == jal || (kind_q == branch && taken)) begin
                    next_pc <= pc + imm_q;
                end else begin
                    next_pc <= pc + addr_w'(4);
                end
                d_addr  <= alu_result;
                d_wdata <= b_q;
            end
            s_mem_wait: begin
                if (!ack_seen && d_bus.ack && kind_q == load) wb_data <= d_bus.rdata;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/mem_bus_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_bus_arbiter (
    input  logic         clk,
    input  logic         rstn,
    mem_bus_if.responder if_bus,
    mem_bus_if.responder d_bus,
    mem_bus_if.requester mem
);
    import core_bus_pkg::*;

    logic busy;
    logic ack_seen;
    logic grant;
    logic pick;
    logic sel;
    logic sel_req;
    logic fetch_owned;
    logic data_owned;

    // data side has priority
    assign pick    = d_bus.req ? rq_data : rq_fetch;
    assign sel     = busy ? grant : pick;
    assign sel_req = (sel == rq_data) ? d_bus.req : if_bus.req;

    // new cycle only with ack low; none after the ack of the held cycle
    assign mem.req   = sel_req && (busy ? !ack_seen : !mem.ack);
    assign mem.addr  = (sel == rq_data) ? d_bus.addr : if_bus.addr;
    assign mem.we    = (sel == rq_data) ? d_bus.we : if_bus.we;
    assign mem.wdata = (sel == rq_data) ? d_bus.wdata : if_bus.wdata;

    assign fetch_owned  = busy && (grant == rq_fetch);
    assign data_owned   = busy && (grant == rq_data);
    assign if_bus.ack   = fetch_owned && mem.ack;
    assign if_bus.rdata = fetch_owned ? mem.rdata : '0;
    assign d_bus.ack    = data_owned && mem.ack;
    assign d_bus.rdata  = data_owned ? mem.rdata : '0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy     <= 1'b0;
            ack_seen <= 1'b0;
            grant    <= rq_fetch;
        end else if (!busy) begin
            if (mem.req) begin
                busy  <= 1'b1;
                grant <= pick;
            end
        end else if (!ack_seen) begin
            if (mem.ack) ack_seen <= 1'b1;
        end else if (!mem.ack) begin
            busy     <= 1'b0;
            ack_seen <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_top (
    input  logic                            clk,
    input  logic                            rstn,
    output logic                            mem_req,
    output logic [core_bus_pkg::addr_w-1:0] mem_addr,
    output logic                            mem_we,
    output logic [core_bus_pkg::word_w-1:0] mem_wdata,
    input  logic                            mem_ack,
    input  logic [core_bus_pkg::word_w-1:0] mem_rdata,
    output logic                            halted
);
    import core_isa_pkg::*;
    import core_bus_pkg::*;

    mem_bus_if if_bus ();
    mem_bus_if d_bus ();
    mem_bus_if mem_bus ();

    logic [word_w-1:0]     inst;
    logic [word_w-1:0]     imm;
    logic [word_w-1:0]     alu_a;
    logic [word_w-1:0]     alu_b;
    logic [word_w-1:0]     alu_result;
    logic [word_w-1:0]     rf_wdata;
    logic [word_w-1:0]     rdata1;
    logic [word_w-1:0]     rdata2;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rf_waddr;
    op_kind_t              kind;
    alu_op_t               alu_op;
    logic                  equal;
    logic                  rf_we;

    core_decode core_decode_i (
        .inst   (inst),
        .kind   (kind),
        .alu_op (alu_op),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .imm    (imm)
    );

    // decoder fields stay valid while the instruction register holds
    core_alu core_alu_i (
        .alu_op (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .equal  (equal)
    );

    core_regfile core_regfile_i (
        .clk    (clk),
        .rstn   (rstn),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    core_control core_control_i (
        .clk        (clk),
        .rstn       (rstn),
        .if_bus     (if_bus.requester),
        .d_bus      (d_bus.requester),
        .halted     (halted),
        .inst       (inst),
        .kind       (kind),
        .rd         (rd),
        .imm        (imm),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .equal      (equal),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .rdata1     (rdata1),
        .rdata2     (rdata2)
    );

    mem_bus_arbiter mem_bus_arbiter_i (
        .clk    (clk),
        .rstn   (rstn),
        .if_bus (if_bus.responder),
        .d_bus  (d_bus.responder),
        .mem    (mem_bus.requester)
    );

    assign mem_req       = mem_bus.req;
    assign mem_addr      = mem_bus.addr;
    assign mem_we        = mem_bus.we;
    assign mem_wdata     = mem_bus.wdata;
    assign mem_bus.ack   = mem_ack;
    assign mem_bus.rdata = mem_rdata;

endmodule

`default_nettype wire

// File: testbench/rv_core_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_asserts (
    input logic                            clk,
    input logic                            rstn,
    input logic                            mem_req,
    input logic [core_bus_pkg::addr_w-1:0] mem_addr,
    input logic                            mem_we,
    input logic [core_bus_pkg::word_w-1:0] mem_wdata,
    input logic                            mem_ack,
    input logic                            halted
);

    ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(mem_ack) |-> $past(mem_req))
        else $error("ack rose without a pending req");

    // request fields frozen until the requester drops req
    fields_stable: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && $past(mem_req)) |-> ($stable(mem_addr) && $stable(mem_we)
                                         && $stable(mem_wdata)))
        else $error("addr, we or wdata changed while req was high");

    req_after_ack_low: assert property (@(posedge clk) disable iff (!rstn)
        $rose(mem_req) |-> !mem_ack)
        else $error("req rose while ack was still high");

    halt_sticky: assert property (@(posedge clk) disable iff (!rstn)
        !$fell(halted))
        else $error("halted fell after being set");

endmodule

bind rv_core_top rv_core_asserts rv_core_asserts_i (.*);

`default_nettype wire

// File: testbench/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    logic        clk;
    logic        rstn;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_we;
    logic [31:0] mem_wdata;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        halted;

    logic [31:0] image [256];
    logic [31:0] mem [256];
    logic [1:0]  delay_tab [1024];
    int          wait_cnt;
    int          txn;

    logic [31:0] exp_addr [$];
    logic        exp_we [$];
    logic [31:0] exp_data [$];
    int          exp_stores = 0;
    int          seen = 0;
    int          stores = 0;
    int          errors = 0;

    rv_core_top rv_core_top_i (
        .clk       (clk),
        .rstn      (rstn),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    always #2 clk = ~clk;

    // instruction encoders
    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic void push_expected(logic [31:0] addr, logic we, logic [31:0] data);
        exp_addr.push_back(addr);
        exp_we.push_back(we);
        exp_data.push_back(data);
    endfunction

    function automatic void build_image();
        for (int i = 0; i < 256; i++) begin
            image[i] = {8'hc3, 8'(i), ~8'(i), 8'(i)};
        end
        image[0]  = i_type(12'h200, 0, 3'b010, 1, 7'h03);
        image[1]  = i_type(12'h204, 0, 3'b010, 2, 7'h03);
        image[2]  = i_type(0, 0, 3'b000, 3, 7'h13);
        image[3]  = i_type(3, 0, 3'b000, 4, 7'h13);
        // sum loop closed by bne
        image[4]  = r_type(7'h00, 1, 3, 3'b000, 3);
        image[5]  = i_type(-1, 4, 3'b000, 4, 7'h13);
        image[6]  = b_type(-8, 0, 4, 3'b001);
        image[7]  = s_type(12'h300, 3, 0);
        image[8]  = r_type(7'h20, 1, 2, 3'b000, 5);
        image[9]  = s_type(12'h304, 5, 0);
        image[10] = r_type(7'h00, 1, 2, 3'b111, 6);
        image[11] = r_type(7'h00, 1, 2, 3'b110, 7);
        image[12] = r_type(7'h00, 1, 2, 3'b100, 8);
        image[13] = s_type(12'h308, 6, 0);
        image[14] = s_type(12'h30c, 7, 0);
        image[15] = s_type(12'h310, 8, 0);
        // countdown loop where beq exits and jal x0 jumps back
        image[16] = i_type(2, 0, 3'b000, 9, 7'h13);
        image[17] = b_type(16, 0, 9, 3'b000);
        image[18] = i_type(-1, 9, 3'b000, 9, 7'h13);
        image[19] = s_type(12'h314, 9, 0);
        image[20] = j_type(-12, 0);
        // jal with link over one skipped word
        image[21] = j_type(8, 10);
        image[22] = i_type(1, 0, 3'b000, 11, 7'h13);
        image[23] = s_type(12'h318, 10, 0);
        image[24] = i_type(7, 0, 3'b000, 0, 7'h13);
        image[25] = s_type(12'h31c, 0, 0);
        image[26] = i_type(12'h20c, 0, 3'b000, 14, 7'h13);
        image[27] = i_type(-4, 14, 3'b010, 13, 7'h03);
        image[28] = s_type(12'h320, 13, 0);
        image[29] = 32'h0000_0000;
        // operands share set bits so and, or and xor all differ
        image[128] = 32'h0000_000c;
        image[129] = 32'h1234_5678;
        image[130] = 32'hdead_beef;
    endfunction

    // instruction-set model of the program
    function automatic void run_reference();
        logic [31:0] rmem [256];
        logic [31:0] rf [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic        wr;
        logic        stop;
        rmem = image;
        rf = '{default: '0};
        pc = '0;
        stop = 1'b0;
        for (int step = 0; step < 2000 && !stop; step++) begin
            push_expected(pc, 1'b0, '0);
            ins = rmem[pc[9:2]];
            a = rf[ins[19:15]];
            b = rf[ins[24:20]];
            next_pc = pc + 4;
            wr = 1'b0;
            res = '0;
            case (ins[6:0])
                7'h33: begin
                    wr = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        10'h000: res = a + b;
                        10'h100: res = a - b;
                        10'h004: res = a ^ b;
                        10'h006: res = a | b;
                        10'h007: res = a & b;
                        default: stop = 1'b1;
                    endcase
                end
                7'h13: begin
                    wr = 1'b1;
                    stop = (ins[14:12] != 3'b000);
                    res = a + {{20{ins[31]}}, ins[31:20]};
                end
                7'h03: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    stop = (ins[14:12] != 3'b010);
                    if (!stop) push_expected(addr, 1'b0, '0);
                    wr = 1'b1;
                    res = rmem[addr[9:2]];
                end
                7'h23: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    stop = (ins[14:12] != 3'b010);
                    if (!stop) begin
                        push_expected(addr, 1'b1, b);
                        rmem[addr[9:2]] = b;
                        exp_stores++;
                    end
                end
                7'h63: begin
                    stop = (ins[14:13] != 2'b00);
                    // funct3 bit 0 inverts the equality for bne
                    if ((a == b) != ins[12]) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                7'h6f: begin
                    wr = 1'b1;
                    res = pc + 4;
                    next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                end
                default: stop = 1'b1;
            endcase
            if (!stop) begin
                if (wr && ins[11:7] != 5'd0) rf[ins[11:7]] = res;
                pc = next_pc;
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // memory model that acks after 0 to 3 idle cycles
    always @(posedge clk) begin
        if (!rstn) begin
            mem_ack <= 1'b0;
            wait_cnt <= 0;
            txn <= 0;
        end else if (mem_ack) begin
            if (!mem_req) mem_ack <= 1'b0;
        end else if (mem_req) begin
            if (wait_cnt == delay_tab[txn % 1024]) begin
                mem_ack <= 1'b1;
                mem_rdata <= mem[mem_addr[9:2]];
                if (mem_we) mem[mem_addr[9:2]] <= mem_wdata;
                wait_cnt <= 0;
                txn <= txn + 1;
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

    // one compare per completed handshake
    always @(posedge clk) begin
        if (rstn && mem_req && mem_ack) begin
            assert (seen < exp_addr.size()) else begin
                $display("bus cycle %0d at address %h was not expected", seen, mem_addr);
                errors++;
            end
            if (seen < exp_addr.size()) begin
                check_value("mem_addr", mem_addr, exp_addr[seen]);
                check_value("mem_we", 32'(mem_we), 32'(exp_we[seen]));
                if (exp_we[seen]) check_value("mem_wdata", mem_wdata, exp_data[seen]);
            end
            if (mem_we) stores++;
            seen++;
        end
    end

    initial begin
        int cycles;
        clk = 1'b0;
        rstn = 1'b0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        void'($urandom(32'hf73d_ca4b));
        for (int i = 0; i < 1024; i++) begin
            delay_tab[i] = 2'($urandom % 4);
        end
        build_image();
        mem = image;
        run_reference();
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        cycles = 0;
        while (!halted && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timeout: core did not halt within %0d cycles", cycles);
            errors++;
        end else begin
            // bus must stay quiet once halted
            for (int i = 0; i < 50; i++) begin
                @(posedge clk);
                assert (!mem_req) else begin
                    $display("memory request seen %0d cycles after halt", i);
                    errors++;
                end
            end
        end
        check_value("store count", stores, exp_stores);
        check_value("bus cycle count", seen, exp_addr.size());
        $display("errors: %0d, bus cycles: %0d, stores: %0d", errors, seen, stores);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
hw/core_isa_pkg.sv
hw/core_bus_pkg.sv
hw/mem_bus_if.sv
hw/core_decode.sv
hw/core_alu.sv
hw/core_regfile.sv
hw/core_control.sv
hw/mem_bus_arbiter.sv
hw/rv_core_top.sv
testbench/rv_core_asserts.sv
testbench/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - hw/core_isa_pkg.sv
      - hw/core_bus_pkg.sv
      - hw/mem_bus_if.sv
      - hw/core_decode.sv
      - hw/core_alu.sv
      - hw/core_regfile.sv
      - hw/core_control.sv
      - hw/mem_bus_arbiter.sv
      - hw/rv_core_top.sv
  - target: test
    files:
      - testbench/rv_core_asserts.sv
      - testbench/tb_rv_core.sv
